//--- logic/ci_defines.svh
`ifndef CI_DEFINES_SVH
`define CI_DEFINES_SVH

// image size with one window per pixel position
`define CI_COLS 11
`define CI_ROWS 11

`define CI_WIN_COUNT (`CI_COLS * `CI_ROWS)  // windows in each pass

`define CI_PIX_W 8   // pixel and centre value
`define CI_SUM_W 15  // covers 121 * 255
`define CI_CNT_W 7   // window index and divider remainder

`endif

//--- logic/ci_pkg.sv
`include "ci_defines.svh"

package ci_pkg;

    typedef logic [`CI_PIX_W-1:0] pix_t;
    typedef logic [`CI_SUM_W-1:0] sum_t;
    typedef logic [`CI_CNT_W-1:0] cnt_t;

    // frame sequencing
    typedef enum logic [1:0] {
        IDLE,
        ACCUM,
        DIVIDE,
        CLASSIFY
    } ci_state_t;

endpackage

//--- logic/ci_counter.sv
`timescale 1ns/10ps

`include "ci_defines.svh"

module ci_counter (
    input  logic clk,
    input  logic rst,
    input  logic clr_i,
    input  logic en_i,
    output logic last_o
);

    ci_pkg::cnt_t cnt;

    assign last_o = (cnt == ci_pkg::cnt_t'(`CI_WIN_COUNT - 1));

    always_ff @(posedge clk) begin
        if (rst || clr_i) begin
            cnt <= '0;
        end else if (en_i) begin
            if (last_o)
                cnt <= '0;  // wrap so the next pass starts clean
            else
                cnt <= cnt + 1'b1;
        end
    end

endmodule

//--- logic/ci_center_filter.sv
`timescale 1ns/10ps

`include "ci_defines.svh"

module ci_center_filter (
    input  logic         clk,
    input  logic         rst,
    input  logic         valid_i,
    input  ci_pkg::pix_t s1_i,
    input  ci_pkg::pix_t s2_i,
    input  ci_pkg::pix_t s3_i,
    input  ci_pkg::pix_t s4_i,
    input  ci_pkg::pix_t s5_i,
    input  ci_pkg::pix_t s6_i,
    input  ci_pkg::pix_t s7_i,
    input  ci_pkg::pix_t s8_i,
    input  ci_pkg::pix_t s9_i,
    output ci_pkg::pix_t center_o,
    output logic         center_valid_o
);

    localparam int WSUM_W = `CI_PIX_W + 4;  // total weight is 16

    logic [WSUM_W-1:0] wsum;

    always_comb begin
        wsum = {1'b0, s5_i, 3'b000};  // centre times 8
        wsum = wsum + s1_i + s2_i + s3_i + s4_i;
        wsum = wsum + s6_i + s7_i + s8_i + s9_i;
    end

    always_ff @(posedge clk) begin
        center_o <= wsum[WSUM_W-1:4];
        if (rst)
            center_valid_o <= 1'b0;
        else
            center_valid_o <= valid_i;
    end

endmodule

//--- logic/ci_accum.sv
`timescale 1ns/10ps

module ci_accum (
    input  logic         clk,
    input  logic         rst,
    input  logic         clr_i,
    input  logic         en_i,
    input  ci_pkg::pix_t center_i,
    output ci_pkg::sum_t sum_o
);

    ci_pkg::sum_t sum_q;

    // frame total of smoothed centres
    always_ff @(posedge clk) begin
        if (rst || clr_i) begin
            sum_q <= '0;
        end else if (en_i) begin
            sum_q <= sum_q + ci_pkg::sum_t'(center_i);
        end
    end

    assign sum_o = sum_q;

endmodule

//--- logic/ci_mean_div.sv
`timescale 1ns/10ps

`include "ci_defines.svh"

module ci_mean_div (
    input  logic         clk,
    input  logic         rst,
    input  logic         start_i,
    input  ci_pkg::sum_t sum_i,
    output ci_pkg::pix_t muy_o,
    output ci_pkg::cnt_t rem_o,
    output logic         done_o
);

    localparam int STEP_W = $clog2(`CI_SUM_W);

    ci_pkg::sum_t          quo;     // dividend shifts out, quotient shifts in
    ci_pkg::cnt_t          rem;
    logic [STEP_W-1:0]     step;
    logic                  busy;
    ci_pkg::sum_t          quo_cur;
    ci_pkg::cnt_t          rem_cur;
    logic [`CI_CNT_W:0]    trial;
    logic [`CI_CNT_W:0]    diff;
    logic                  qbit;

    // first step happens on the start edge, so start feeds the datapath directly
    assign quo_cur = start_i ? sum_i : quo;
    assign rem_cur = start_i ? '0 : rem;

    always_comb begin
        trial = {rem_cur, quo_cur[`CI_SUM_W-1]};
        diff  = trial - (`CI_CNT_W + 1)'(`CI_WIN_COUNT);
        qbit  = (trial >= (`CI_CNT_W + 1)'(`CI_WIN_COUNT));
    end

    always_ff @(posedge clk) begin
        if (start_i || busy) begin
            quo <= {quo_cur[`CI_SUM_W-2:0], qbit};
            rem <= qbit ? diff[`CI_CNT_W-1:0] : trial[`CI_CNT_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            step   <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                busy <= 1'b1;
                step <= STEP_W'(1);
            end else if (busy) begin
                step <= step + 1'b1;
                if (step == STEP_W'(`CI_SUM_W - 1)) begin  // final quotient bit
                    busy   <= 1'b0;
                    done_o <= 1'b1;
                end
            end
        end
    end

    // mean fits in a pixel since every centre does
    assign muy_o = quo[`CI_PIX_W-1:0];
    assign rem_o = rem;

endmodule

//--- logic/ci_threshold.sv
`timescale 1ns/10ps

module ci_threshold (
    input  logic         clk,
    input  logic         rst,
    input  logic         load_i,
    input  ci_pkg::pix_t muy_i,
    input  ci_pkg::cnt_t rem_i,
    input  logic         cls_en_i,
    input  ci_pkg::pix_t center_i,
    output logic         ci_o,
    output logic         ci_valid_o
);

    ci_pkg::pix_t muy_q;
    ci_pkg::cnt_t rem_q;
    logic         ci_bit;

    always_ff @(posedge clk) begin
        if (load_i) begin
            muy_q <= muy_i;
            rem_q <= rem_i;
        end
    end

    // equal to the truncated mean only counts when the mean is exact
    assign ci_bit = (center_i > muy_q) || ((center_i == muy_q) && (rem_q == '0));

    always_ff @(posedge clk) begin
        if (rst) begin
            ci_o       <= 1'b0;
            ci_valid_o <= 1'b0;
        end else begin
            ci_valid_o <= cls_en_i;
            if (cls_en_i)
                ci_o <= ci_bit;
        end
    end

endmodule

//--- logic/ci_ctrl.sv
`timescale 1ns/10ps

module ci_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic start_i,
    input  logic center_valid_i,
    input  logic cnt_last_i,
    input  logic div_done_i,
    output logic cnt_clr_o,
    output logic cnt_en_o,
    output logic acc_en_o,
    output logic cls_en_o,
    output logic div_start_o,
    output logic progress_done_o,
    output logic done_o
);

    ci_pkg::ci_state_t state;
    ci_pkg::ci_state_t state_nxt;
    logic acc_end;     // last window of accumulate pass
    logic cls_end;     // last window of classify pass
    logic div_start_q;
    logic done_q;

    assign cnt_clr_o = (state == ci_pkg::IDLE) && start_i;
    assign acc_en_o  = center_valid_i && (state == ci_pkg::ACCUM);
    assign cls_en_o  = center_valid_i && (state == ci_pkg::CLASSIFY);
    assign cnt_en_o  = acc_en_o || cls_en_o;  // windows in IDLE and DIVIDE are dropped

    assign acc_end = acc_en_o && cnt_last_i;
    assign cls_end = cls_en_o && cnt_last_i;

    always_comb begin
        state_nxt = state;
        case (state)
            ci_pkg::IDLE:     if (start_i)    state_nxt = ci_pkg::ACCUM;
            ci_pkg::ACCUM:    if (acc_end)    state_nxt = ci_pkg::DIVIDE;
            ci_pkg::DIVIDE:   if (div_done_i) state_nxt = ci_pkg::CLASSIFY;
            ci_pkg::CLASSIFY: if (cls_end)    state_nxt = ci_pkg::IDLE;
            default:          state_nxt = ci_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ci_pkg::IDLE;
            div_start_q <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            state       <= state_nxt;
            div_start_q <= acc_end;  // sum is complete one edge later
            done_q      <= (state == ci_pkg::DIVIDE) && div_done_i;
        end
    end

    // divider start doubles as the end-of-accumulate pulse
    assign div_start_o     = div_start_q;
    assign progress_done_o = div_start_q;
    assign done_o          = done_q;

endmodule

//--- logic/ci_r4_top.sv
`timescale 1ns/10ps

module ci_r4_top (
    input  logic         clk,
    input  logic         rst,
    input  logic         start_i,
    input  logic         win_valid_i,
    input  ci_pkg::pix_t s1_i,
    input  ci_pkg::pix_t s2_i,
    input  ci_pkg::pix_t s3_i,
    input  ci_pkg::pix_t s4_i,
    input  ci_pkg::pix_t s5_i,  // centre pixel
    input  ci_pkg::pix_t s6_i,
    input  ci_pkg::pix_t s7_i,
    input  ci_pkg::pix_t s8_i,
    input  ci_pkg::pix_t s9_i,
    output logic         ci_o,
    output logic         ci_valid_o,
    output logic         progress_done_o,
    output logic         done_o
);

    ci_pkg::pix_t center;
    logic         center_valid;
    logic         cnt_clr;
    logic         cnt_en;
    logic         cnt_last;
    logic         acc_en;
    logic         cls_en;
    logic         div_start;
    logic         div_done;
    ci_pkg::sum_t sum;
    ci_pkg::pix_t muy;
    ci_pkg::cnt_t rem;

    ci_center_filter u_filter (
        .clk            (clk),
        .rst            (rst),
        .valid_i        (win_valid_i),
        .s1_i           (s1_i),
        .s2_i           (s2_i),
        .s3_i           (s3_i),
        .s4_i           (s4_i),
        .s5_i           (s5_i),
        .s6_i           (s6_i),
        .s7_i           (s7_i),
        .s8_i           (s8_i),
        .s9_i           (s9_i),
        .center_o       (center),
        .center_valid_o (center_valid)
    );

    ci_ctrl u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .start_i         (start_i),
        .center_valid_i  (center_valid),
        .cnt_last_i      (cnt_last),
        .div_done_i      (div_done),
        .cnt_clr_o       (cnt_clr),
        .cnt_en_o        (cnt_en),
        .acc_en_o        (acc_en),
        .cls_en_o        (cls_en),
        .div_start_o     (div_start),
        .progress_done_o (progress_done_o),
        .done_o          (done_o)
    );

    ci_counter u_counter (
        .clk    (clk),
        .rst    (rst),
        .clr_i  (cnt_clr),
        .en_i   (cnt_en),
        .last_o (cnt_last)
    );

    ci_accum u_accum (
        .clk      (clk),
        .rst      (rst),
        .clr_i    (cnt_clr),
        .en_i     (acc_en),
        .center_i (center),
        .sum_o    (sum)
    );

    ci_mean_div u_div (
        .clk     (clk),
        .rst     (rst),
        .start_i (div_start),
        .sum_i   (sum),
        .muy_o   (muy),
        .rem_o   (rem),
        .done_o  (div_done)
    );

    ci_threshold u_thresh (
        .clk        (clk),
        .rst        (rst),
        .load_i     (div_done),
        .muy_i      (muy),
        .rem_i      (rem),
        .cls_en_i   (cls_en),
        .center_i   (center),
        .ci_o       (ci_o),
        .ci_valid_o (ci_valid_o)
    );

endmodule

//--- testbench/ci_r4_chk.sv
`timescale 1ns/10ps

`include "ci_defines.svh"

module ci_r4_chk (
    input logic clk,
    input logic rst,
    input logic ci_valid_o,
    input logic progress_done_o,
    input logic done_o
);

    localparam int DONE_LAT = `CI_SUM_W + 1;  // divide phase has a fixed length

    done_needs_progress_a: assert property (@(posedge clk) disable iff (rst)
        done_o |-> $past(progress_done_o, DONE_LAT))
        else $error("done_o without progress_done_o %0d cycles earlier", DONE_LAT);

    progress_gives_done_a: assert property (@(posedge clk) disable iff (rst)
        $past(progress_done_o, DONE_LAT) |-> done_o)
        else $error("no done_o %0d cycles after progress_done_o", DONE_LAT);

    // first cycle out of reset sees the reset values
    outputs_clear_after_reset_a: assert property (@(posedge clk)
        (!rst && $past(rst)) |-> (!ci_valid_o && !progress_done_o && !done_o))
        else $error("outputs not low coming out of reset");

    progress_single_pulse_a: assert property (@(posedge clk) disable iff (rst)
        progress_done_o |-> !$past(progress_done_o))
        else $error("progress_done_o high on consecutive cycles");

    done_single_pulse_a: assert property (@(posedge clk) disable iff (rst)
        done_o |-> (!$past(done_o) && !$past(progress_done_o)))
        else $error("done_o adjacent to another pulse");

endmodule

bind ci_r4_top ci_r4_chk chk0 (
    .clk             (clk),
    .rst             (rst),
    .ci_valid_o      (ci_valid_o),
    .progress_done_o (progress_done_o),
    .done_o          (done_o)
);

//--- testbench/ci_r4_tb.sv
`timescale 1ns/10ps

`include "ci_defines.svh"

module ci_r4_tb;

    localparam int NFRAMES     = 3;
    localparam int WIN         = `CI_WIN_COUNT;
    localparam int PRE_WINS    = 4;  // offered while idle and must be dropped
    localparam int DIV_WINS    = 6;  // offered during the divide phase
    localparam int WDOG_CYCLES = NFRAMES * (3 * WIN + `CI_SUM_W + 20);

    logic         clk;
    logic         rst;
    logic         start_i;
    logic         win_valid_i;
    ci_pkg::pix_t win_pix [9];
    logic         ci_o;
    logic         ci_valid_o;
    logic         progress_done_o;
    logic         done_o;

    // -1 full range random, -2 narrow range random, otherwise a constant pixel
    int           frame_fill [NFRAMES] = '{-1, 'h5a, -2};
    ci_pkg::pix_t acc_pix [NFRAMES][WIN][9];
    ci_pkg::pix_t cls_pix [NFRAMES][WIN][9];
    bit           exp_ci [NFRAMES][WIN];
    int           exp_muy [NFRAMES];
    int           exp_rem [NFRAMES];

    integer       seed;
    ci_pkg::pix_t cur_win [9];
    bit           civ_pipe [2];  // expected outputs two cycles after the drive
    bit           ci_pipe [2];
    bit           pd_pipe [2];
    int           done_wait;
    bit           saw_done;

    ci_r4_top dut0 (
        .clk             (clk),
        .rst             (rst),
        .start_i         (start_i),
        .win_valid_i     (win_valid_i),
        .s1_i            (win_pix[0]),
        .s2_i            (win_pix[1]),
        .s3_i            (win_pix[2]),
        .s4_i            (win_pix[3]),
        .s5_i            (win_pix[4]),
        .s6_i            (win_pix[5]),
        .s7_i            (win_pix[6]),
        .s8_i            (win_pix[7]),
        .s9_i            (win_pix[8]),
        .ci_o            (ci_o),
        .ci_valid_o      (ci_valid_o),
        .progress_done_o (progress_done_o),
        .done_o          (done_o)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic ci_pkg::pix_t rand_pix(input int fill);
        int r;
        r = $random(seed);
        if (fill == -2)
            return ci_pkg::pix_t'(32'h40 | (r & 32'h3f));
        return ci_pkg::pix_t'(r);
    endfunction

    // weight 8 on the centre, 1 on each neighbour, divided by 16
    function automatic int center_of(input int f, input int w, input bit cls);
        int total;
        int px;
        total = 0;
        for (int k = 0; k < 9; k++) begin
            px = cls ? int'(cls_pix[f][w][k]) : int'(acc_pix[f][w][k]);
            total += (k == 4) ? 8 * px : px;
        end
        return total / 16;
    endfunction

    function automatic bit ci_of(input int c, input int muy, input int r);
        return (c > muy) || ((c == muy) && (r == 0));
    endfunction

    task automatic build_table();
        int sum;
        int fill;
        for (int f = 0; f < NFRAMES; f++) begin
            fill = frame_fill[f];
            sum  = 0;
            for (int w = 0; w < WIN; w++) begin
                for (int k = 0; k < 9; k++)
                    acc_pix[f][w][k] = (fill >= 0) ? ci_pkg::pix_t'(fill) : rand_pix(fill);
                sum += center_of(f, w, 1'b0);
            end
            exp_muy[f] = sum / WIN;
            exp_rem[f] = sum % WIN;
            for (int w = 0; w < WIN; w++) begin
                for (int k = 0; k < 9; k++)  // even windows of a flat frame hit the mean
                    cls_pix[f][w][k] = (fill >= 0 && w % 2 == 0) ? ci_pkg::pix_t'(fill)
                                                                  : rand_pix(-1);
                exp_ci[f][w] = ci_of(center_of(f, w, 1'b1), exp_muy[f], exp_rem[f]);
            end
        end
    endtask

    task automatic load_window(input int f, input int w, input bit cls);
        for (int k = 0; k < 9; k++)
            cur_win[k] = cls ? cls_pix[f][w][k] : acc_pix[f][w][k];
    endtask

    task automatic random_window();
        for (int k = 0; k < 9; k++)
            cur_win[k] = rand_pix(-1);
    endtask

    // one clock that checks what is due now and then drives the next inputs
    task automatic apply_cycle(input bit start, input bit valid, input bit e_civ,
                               input bit e_ci, input bit e_pd);
        bit exp_done;
        @(posedge clk);
        #2;
        check_value("ci_valid_o", 32'(ci_valid_o), 32'(civ_pipe[1]));
        if (civ_pipe[1])
            check_value("ci_o", 32'(ci_o), 32'(ci_pipe[1]));
        check_value("progress_done_o", 32'(progress_done_o), 32'(pd_pipe[1]));
        if (done_wait >= 0)
            done_wait = done_wait - 1;
        exp_done = (done_wait == 0);
        check_value("done_o", 32'(done_o), 32'(exp_done));
        if (done_o)
            saw_done = 1'b1;
        if (pd_pipe[1])
            done_wait = `CI_SUM_W + 1;
        civ_pipe[1] = civ_pipe[0];
        ci_pipe[1]  = ci_pipe[0];
        pd_pipe[1]  = pd_pipe[0];
        civ_pipe[0] = e_civ;
        ci_pipe[0]  = e_ci;
        pd_pipe[0]  = e_pd;
        start_i     = start;
        win_valid_i = valid;
        for (int k = 0; k < 9; k++)
            win_pix[k] = cur_win[k];
    endtask

    task automatic run_frame(input int f);
        int guard;
        saw_done = 1'b0;
        for (int i = 0; i < PRE_WINS; i++) begin
            random_window();
            apply_cycle(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        end
        apply_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        apply_cycle(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        for (int w = 0; w < WIN; w++) begin
            load_window(f, w, 1'b0);
            apply_cycle(1'b0, 1'b1, 1'b0, 1'b0, w == WIN - 1);
            if (w % 16 == 15)
                apply_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);  // gap in the stream
        end
        for (int i = 0; i < DIV_WINS; i++) begin
            random_window();
            apply_cycle(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        end
        guard = 0;
        while (!saw_done) begin
            if (guard > `CI_SUM_W + 4) begin
                $display("Test FAILED");
                $fatal(1, "done_o never came after the accumulate pass");
            end
            apply_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
            guard++;
        end
        for (int w = 0; w < WIN; w++) begin
            load_window(f, w, 1'b1);
            apply_cycle(1'b0, 1'b1, 1'b1, exp_ci[f][w], 1'b0);
        end
        repeat (3) apply_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);  // drain
    endtask

    initial begin
        #(WDOG_CYCLES * 20);
        $display("Test FAILED");
        $fatal(1, "simulation ran past its time limit");
    end

    initial begin
        seed        = 31439;
        rst         = 1'b1;
        start_i     = 1'b0;
        win_valid_i = 1'b0;
        for (int k = 0; k < 9; k++) begin
            win_pix[k] = '0;
            cur_win[k] = '0;
        end
        for (int i = 0; i < 2; i++) begin
            civ_pipe[i] = 1'b0;
            ci_pipe[i]  = 1'b0;
            pd_pipe[i]  = 1'b0;
        end
        done_wait = -1;
        saw_done  = 1'b0;
        build_table();
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int f = 0; f < NFRAMES; f++)
            run_frame(f);
        $display("Test OK");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+logic
logic/ci_pkg.sv
logic/ci_counter.sv
logic/ci_center_filter.sv
logic/ci_accum.sv
logic/ci_mean_div.sv
logic/ci_threshold.sv
logic/ci_ctrl.sv
logic/ci_r4_top.sv
testbench/ci_r4_chk.sv
testbench/ci_r4_tb.sv

//--- run.sh
#!/bin/sh
# build and run the CI bit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module ci_r4_tb \
    -f verilog.f \
    -o sim_ci_r4

./obj_dir/sim_ci_r4
